// ==== source/rv_exec_config.svh ====
// widths are fixed for RV64; memory is word addressed by double word, byte offsets dropped
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// data, operand, pc and csr width
`define RV_WORD_WD 64

// immediate arrives already sign extended to this width
`define RV_IMM_WD 64

// double-word index bits of the data memory
`define RV_MEM_AW 8

// entries of 64 bits each
`define RV_MEM_DEPTH (1 << `RV_MEM_AW)

// low byte-address bits dropped when indexing the memory
`define RV_MEM_OFS 3

`endif

// ==== source/rv_exec_pkg.sv ====
// encodings must match the decoder; src2 select values follow the existing execute unit
`default_nettype none

package rv_exec_pkg;

  typedef enum logic [4:0] {
    ALU_ADD    = 5'd0,
    ALU_SUB    = 5'd1,
    ALU_SLL    = 5'd2,
    ALU_SLT    = 5'd3,
    ALU_SLTU   = 5'd4,
    ALU_XOR    = 5'd5,
    ALU_SRL    = 5'd6,
    ALU_SRA    = 5'd7,
    ALU_OR     = 5'd8,
    ALU_AND    = 5'd9,
    // lui passes the immediate through
    ALU_PASS_B = 5'd10
  } alu_op_t;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'b00,
    SRC2_IMM  = 2'b01,
    SRC2_FOUR = 2'b10
  } src2_sel_t;

  typedef enum logic [3:0] {
    CSR_NONE  = 4'd0,
    CSR_WRITE = 4'd1,
    CSR_SET   = 4'd2,
    CSR_CLEAR = 4'd3
  } csr_op_t;

  typedef enum logic [2:0] {
    MEM_NONE = 3'd0,
    MEM_LW   = 3'd1,
    MEM_LD   = 3'd2,
    MEM_SW   = 3'd3,
    MEM_SD   = 3'd4
  } mem_op_t;

endpackage

`default_nettype wire

// ==== source/rv_alu.sv ====
// purely combinational; in word mode operands are expected already cut to 32 bits
`timescale 1ns/1ps
`default_nettype none
`include "rv_exec_config.svh"

module rv_alu import rv_exec_pkg::*; (
  input  wire logic [`RV_WORD_WD-1:0] i_src_a,
  input  wire logic [`RV_WORD_WD-1:0] i_src_b,
  input  wire alu_op_t                i_alu_op,
  input  wire logic                   i_alu_word_cut_sel,
  output logic      [`RV_WORD_WD-1:0] o_alu_result
);

  logic [5:0]              shamt;
  logic [31:0]             sra_word;
  logic [`RV_WORD_WD-1:0]  sra_dword;
  logic [`RV_WORD_WD-1:0]  srl_res;
  logic [`RV_WORD_WD-1:0]  sra_res;
  logic [`RV_WORD_WD-1:0]  raw_res;

  // word shifts only look at 5 bits of the amount
  assign shamt = i_alu_word_cut_sel ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];

  assign sra_word  = $signed(i_src_a[31:0]) >>> shamt[4:0];
  assign sra_dword = $signed(i_src_a) >>> shamt;

  // upper half of src_a is zero in word mode, so a plain shift is enough
  assign srl_res = i_src_a >> shamt;
  assign sra_res = i_alu_word_cut_sel ? {{32{sra_word[31]}}, sra_word} : sra_dword;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:    raw_res = i_src_a + i_src_b;
      ALU_SUB:    raw_res = i_src_a - i_src_b;
      ALU_SLL:    raw_res = i_src_a << shamt;
      ALU_SLT: begin
        raw_res = {{(`RV_WORD_WD-1){1'b0}}, ($signed(i_src_a) < $signed(i_src_b))};
      end
      ALU_SLTU: begin
        raw_res = {{(`RV_WORD_WD-1){1'b0}}, (i_src_a < i_src_b)};
      end
      ALU_XOR:    raw_res = i_src_a ^ i_src_b;
      ALU_SRL:    raw_res = srl_res;
      ALU_SRA:    raw_res = sra_res;
      ALU_OR:     raw_res = i_src_a | i_src_b;
      ALU_AND:    raw_res = i_src_a & i_src_b;
      ALU_PASS_B: raw_res = i_src_b;
      default:    raw_res = '0;
    endcase
  end

  // word results are sign extended from bit 31
  assign o_alu_result = i_alu_word_cut_sel ? {{32{raw_res[31]}}, raw_res[31:0]} : raw_res;

endmodule

`default_nettype wire

// ==== source/rv_csu.sv ====
// computes the new csr value only; csr storage and privilege checks live elsewhere
`timescale 1ns/1ps
`default_nettype none
`include "rv_exec_config.svh"

module rv_csu import rv_exec_pkg::*; (
  input  wire logic [`RV_WORD_WD-1:0] i_rs1data,
  input  wire logic [`RV_WORD_WD-1:0] i_csrrdata,
  input  wire logic [`RV_IMM_WD-1:0]  i_imm,
  input  wire csr_op_t                i_csr_op,
  input  wire logic                   i_csr_imm_rs1_sel,
  output logic      [`RV_WORD_WD-1:0] o_csr_result
);

  logic [`RV_WORD_WD-1:0] csr_src;

  // csrr*i forms use the zero extended 5-bit uimm
  assign csr_src = i_csr_imm_rs1_sel ? {{(`RV_WORD_WD-5){1'b0}}, i_imm[4:0]} : i_rs1data;

  always_comb begin
    case (i_csr_op)
      CSR_WRITE: o_csr_result = csr_src;
      CSR_SET:   o_csr_result = i_csrrdata | csr_src;
      CSR_CLEAR: o_csr_result = i_csrrdata & ~csr_src;
      default:   o_csr_result = i_csrrdata;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/rv_exu.sv ====
// i_valid must already exclude busy cycles; halt and abort are sticky until i_rst
`timescale 1ns/1ps
`default_nettype none
`include "rv_exec_config.svh"

module rv_exu import rv_exec_pkg::*; (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,
  input  wire logic                   i_valid,
  // operands
  input  wire logic [`RV_WORD_WD-1:0] i_rs1data,
  input  wire logic [`RV_WORD_WD-1:0] i_rs2data,
  input  wire logic [`RV_IMM_WD-1:0]  i_imm,
  input  wire logic [`RV_WORD_WD-1:0] i_pc,
  input  wire logic [`RV_WORD_WD-1:0] i_csrrdata,
  // alu control
  input  wire logic                   i_alu_src1_sel,
  input  wire src2_sel_t              i_alu_src2_sel,
  input  wire alu_op_t                i_alu_op,
  input  wire logic                   i_alu_word_cut_sel,
  // other control
  input  wire csr_op_t                i_csr_op,
  input  wire mem_op_t                i_mem_op,
  input  wire logic                   i_ebreak_sel,
  input  wire logic                   i_invalid_inst_sel,
  // registered result
  output logic                        o_res_valid,
  output logic      [`RV_WORD_WD-1:0] o_res_alu,
  output logic      [`RV_WORD_WD-1:0] o_res_csr,
  output mem_op_t                     o_res_mem_op,
  output logic      [`RV_WORD_WD-1:0] o_res_store_data,
  output logic                        o_halt,
  output logic                        o_abort
);

  logic [`RV_WORD_WD-1:0] src1;
  logic [`RV_WORD_WD-1:0] src2;
  logic [`RV_WORD_WD-1:0] imm;
  logic [`RV_WORD_WD-1:0] src_a;
  logic [`RV_WORD_WD-1:0] src_b;
  logic [`RV_WORD_WD-1:0] alu_result;
  logic [`RV_WORD_WD-1:0] csr_result;
  logic                   csr_imm_rs1_sel;
  logic                   accept;

  // word mode cuts operands to 32 bits, zero extended
  assign src1 = i_alu_word_cut_sel ? {32'b0, i_rs1data[31:0]} : i_rs1data;
  assign src2 = i_alu_word_cut_sel ? {32'b0, i_rs2data[31:0]} : i_rs2data;
  assign imm  = i_alu_word_cut_sel ? {32'b0, i_imm[31:0]} : i_imm;

  assign src_a = i_alu_src1_sel ? i_pc : src1;

  always_comb begin
    case (i_alu_src2_sel)
      SRC2_RS2:  src_b = src2;
      SRC2_IMM:  src_b = imm;
      SRC2_FOUR: src_b = `RV_WORD_WD'd4;
      default:   src_b = '0;
    endcase
  end

  rv_alu u_alu (
    .i_src_a            (src_a),
    .i_src_b            (src_b),
    .i_alu_op           (i_alu_op),
    .i_alu_word_cut_sel (i_alu_word_cut_sel),
    .o_alu_result       (alu_result)
  );

  assign csr_imm_rs1_sel = (i_alu_src2_sel == SRC2_IMM);

  rv_csu u_csu (
    .i_rs1data         (i_rs1data),
    .i_csrrdata        (i_csrrdata),
    .i_imm             (i_imm),
    .i_csr_op          (i_csr_op),
    .i_csr_imm_rs1_sel (csr_imm_rs1_sel),
    .o_csr_result      (csr_result)
  );

  assign accept = i_valid && !o_halt && !o_abort;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_res_valid <= 1'b0;
      o_halt      <= 1'b0;
      o_abort     <= 1'b0;
    end else begin
      // ebreak and invalid ops stop the core without writing back
      o_res_valid <= accept && !i_ebreak_sel && !i_invalid_inst_sel;
      if (accept && i_ebreak_sel) begin
        o_halt <= 1'b1;
      end
      if (accept && i_invalid_inst_sel) begin
        o_abort <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_res_alu        <= alu_result;
      o_res_csr        <= csr_result;
      o_res_mem_op     <= i_mem_op;
      o_res_store_data <= i_rs2data;
    end
  end

endmodule

`default_nettype wire

// ==== source/rv_lsu.sv ====
// one memory op in flight; the memory never stalls it and misaligned accesses are not checked
`timescale 1ns/1ps
`default_nettype none
`include "rv_exec_config.svh"

module rv_lsu import rv_exec_pkg::*; (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,
  input  wire logic                   i_res_valid,
  input  wire logic [`RV_WORD_WD-1:0] i_res_alu,
  input  wire logic [`RV_WORD_WD-1:0] i_res_csr,
  input  wire mem_op_t                i_res_mem_op,
  input  wire logic [`RV_WORD_WD-1:0] i_res_store_data,
  input  wire logic [`RV_WORD_WD-1:0] i_mem_rdata,
  output logic                        o_mem_req,
  output logic                        o_mem_we,
  output logic      [1:0]             o_mem_word,
  output logic      [`RV_MEM_AW-1:0]  o_mem_addr,
  output logic      [`RV_WORD_WD-1:0] o_mem_wdata,
  output logic                        o_busy,
  output logic                        o_wb_valid,
  output logic      [`RV_WORD_WD-1:0] o_wb_data,
  output logic      [`RV_WORD_WD-1:0] o_csr_result
);

  logic                   is_mem;
  logic                   is_load;
  logic                   is_word;
  logic                   wb_valid_q;
  logic [`RV_WORD_WD-1:0] wb_data_q;
  logic                   ld_pend_q;
  logic                   ld_word_q;
  logic                   ld_half_q;
  logic [31:0]            ld_half;
  logic [`RV_WORD_WD-1:0] ld_data;

  assign is_mem  = i_res_valid && (i_res_mem_op != MEM_NONE);
  assign is_load = (i_res_mem_op == MEM_LW) || (i_res_mem_op == MEM_LD);
  assign is_word = (i_res_mem_op == MEM_LW) || (i_res_mem_op == MEM_SW);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mem_req  <= 1'b0;
      wb_valid_q <= 1'b0;
      ld_pend_q  <= 1'b0;
    end else begin
      o_mem_req  <= is_mem;
      wb_valid_q <= i_res_valid && !is_mem;
      // read data comes back the cycle after the request
      ld_pend_q  <= o_mem_req && !o_mem_we;
    end
  end

  always_ff @(posedge i_clk) begin
    if (is_mem) begin
      o_mem_we    <= !is_load;
      o_mem_addr  <= i_res_alu[`RV_MEM_AW+`RV_MEM_OFS-1:`RV_MEM_OFS];
      // half strobes; bit 2 of the byte address picks the upper word
      o_mem_word  <= is_word ? (i_res_alu[2] ? 2'b10 : 2'b01) : 2'b11;
      o_mem_wdata <= is_word ? {2{i_res_store_data[31:0]}} : i_res_store_data;
      ld_word_q   <= is_word;
      ld_half_q   <= i_res_alu[2];
    end
    if (i_res_valid) begin
      wb_data_q    <= i_res_alu;
      o_csr_result <= i_res_csr;
    end
  end

  assign ld_half = ld_half_q ? i_mem_rdata[63:32] : i_mem_rdata[31:0];
  assign ld_data = ld_word_q ? {{32{ld_half[31]}}, ld_half} : i_mem_rdata;

  assign o_wb_valid = wb_valid_q || ld_pend_q;
  assign o_wb_data  = ld_pend_q ? ld_data : wb_data_q;

  // covers the result cycle, the request cycle and a load's return cycle
  assign o_busy = is_mem || o_mem_req || ld_pend_q;

endmodule

`default_nettype wire

// ==== source/rv_shared_dmem.sv ====
// one access per cycle, load/store unit always wins; host addresses are double-word indices
`timescale 1ns/1ps
`default_nettype none
`include "rv_exec_config.svh"

module rv_shared_dmem (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,
  // load/store port
  input  wire logic                   i_lsu_req,
  input  wire logic                   i_lsu_we,
  input  wire logic [1:0]             i_lsu_word,
  input  wire logic [`RV_MEM_AW-1:0]  i_lsu_addr,
  input  wire logic [`RV_WORD_WD-1:0] i_lsu_wdata,
  output logic      [`RV_WORD_WD-1:0] o_lsu_rdata,
  // host port
  input  wire logic                   i_host_req,
  input  wire logic                   i_host_we,
  input  wire logic [`RV_MEM_AW-1:0]  i_host_addr,
  input  wire logic [`RV_WORD_WD-1:0] i_host_wdata,
  output logic                        o_host_gnt,
  output logic      [`RV_WORD_WD-1:0] o_host_rdata,
  output logic                        o_host_rvalid
);

  logic [`RV_WORD_WD-1:0] mem [`RV_MEM_DEPTH];

  logic                   acc_en;
  logic                   acc_we;
  logic [1:0]             acc_strb;
  logic [`RV_MEM_AW-1:0]  acc_addr;
  logic [`RV_WORD_WD-1:0] acc_wdata;
  logic [`RV_WORD_WD-1:0] rdata_q;

  // host only gets the cycles the load/store unit leaves idle
  assign o_host_gnt = i_host_req && !i_lsu_req;

  always_comb begin
    if (i_lsu_req) begin
      acc_we    = i_lsu_we;
      acc_strb  = i_lsu_word;
      acc_addr  = i_lsu_addr;
      acc_wdata = i_lsu_wdata;
    end else begin
      acc_we    = i_host_we;
      acc_strb  = 2'b11;
      acc_addr  = i_host_addr;
      acc_wdata = i_host_wdata;
    end
  end

  assign acc_en = i_lsu_req || o_host_gnt;

  always_ff @(posedge i_clk) begin
    if (acc_en && acc_we) begin
      if (acc_strb[0]) begin
        mem[acc_addr][31:0] <= acc_wdata[31:0];
      end
      if (acc_strb[1]) begin
        mem[acc_addr][63:32] <= acc_wdata[63:32];
      end
    end
    // read register holds its value between reads
    if (acc_en && !acc_we) begin
      rdata_q <= mem[acc_addr];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_host_rvalid <= 1'b0;
    end else begin
      o_host_rvalid <= o_host_gnt && !i_host_we;
    end
  end

  assign o_lsu_rdata  = rdata_q;
  assign o_host_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== source/rv_exec_top.sv ====
// i_valid is dropped while o_busy is high; the host must hold its request until o_host_gnt
`timescale 1ns/1ps
`default_nettype none
`include "rv_exec_config.svh"

module rv_exec_top import rv_exec_pkg::*; (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,
  input  wire logic                   i_valid,
  input  wire logic [`RV_WORD_WD-1:0] i_rs1data,
  input  wire logic [`RV_WORD_WD-1:0] i_rs2data,
  input  wire logic [`RV_IMM_WD-1:0]  i_imm,
  input  wire logic [`RV_WORD_WD-1:0] i_pc,
  input  wire logic [`RV_WORD_WD-1:0] i_csrrdata,
  input  wire logic                   i_alu_src1_sel,
  input  wire src2_sel_t              i_alu_src2_sel,
  input  wire alu_op_t                i_alu_op,
  input  wire logic                   i_alu_word_cut_sel,
  input  wire csr_op_t                i_csr_op,
  input  wire mem_op_t                i_mem_op,
  input  wire logic                   i_ebreak_sel,
  input  wire logic                   i_invalid_inst_sel,
  output logic                        o_busy,
  output logic                        o_wb_valid,
  output logic      [`RV_WORD_WD-1:0] o_wb_data,
  output logic      [`RV_WORD_WD-1:0] o_csr_result,
  output logic                        o_halt,
  output logic                        o_abort,
  // host access port
  input  wire logic                   i_host_req,
  input  wire logic                   i_host_we,
  input  wire logic [`RV_MEM_AW-1:0]  i_host_addr,
  input  wire logic [`RV_WORD_WD-1:0] i_host_wdata,
  output logic                        o_host_gnt,
  output logic      [`RV_WORD_WD-1:0] o_host_rdata,
  output logic                        o_host_rvalid
);

  logic                   res_valid;
  logic [`RV_WORD_WD-1:0] res_alu;
  logic [`RV_WORD_WD-1:0] res_csr;
  mem_op_t                res_mem_op;
  logic [`RV_WORD_WD-1:0] res_store_data;
  logic                   lsu_req;
  logic                   lsu_we;
  logic [1:0]             lsu_wstrb_word;
  logic [`RV_MEM_AW-1:0]  lsu_addr;
  logic [`RV_WORD_WD-1:0] lsu_wdata;
  logic [`RV_WORD_WD-1:0] lsu_rdata;

  // new ops are only taken while the load/store unit is idle
  wire exu_valid = i_valid && !o_busy;

  rv_exu u_exu (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_valid            (exu_valid),
    .i_rs1data          (i_rs1data),
    .i_rs2data          (i_rs2data),
    .i_imm              (i_imm),
    .i_pc               (i_pc),
    .i_csrrdata         (i_csrrdata),
    .i_alu_src1_sel     (i_alu_src1_sel),
    .i_alu_src2_sel     (i_alu_src2_sel),
    .i_alu_op           (i_alu_op),
    .i_alu_word_cut_sel (i_alu_word_cut_sel),
    .i_csr_op           (i_csr_op),
    .i_mem_op           (i_mem_op),
    .i_ebreak_sel       (i_ebreak_sel),
    .i_invalid_inst_sel (i_invalid_inst_sel),
    .o_res_valid        (res_valid),
    .o_res_alu          (res_alu),
    .o_res_csr          (res_csr),
    .o_res_mem_op       (res_mem_op),
    .o_res_store_data   (res_store_data),
    .o_halt             (o_halt),
    .o_abort            (o_abort)
  );

  rv_lsu u_lsu (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_res_valid      (res_valid),
    .i_res_alu        (res_alu),
    .i_res_csr        (res_csr),
    .i_res_mem_op     (res_mem_op),
    .i_res_store_data (res_store_data),
    .i_mem_rdata      (lsu_rdata),
    .o_mem_req        (lsu_req),
    .o_mem_we         (lsu_we),
    .o_mem_word       (lsu_wstrb_word),
    .o_mem_addr       (lsu_addr),
    .o_mem_wdata      (lsu_wdata),
    .o_busy           (o_busy),
    .o_wb_valid       (o_wb_valid),
    .o_wb_data        (o_wb_data),
    .o_csr_result     (o_csr_result)
  );

  rv_shared_dmem u_dmem (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_lsu_req     (lsu_req),
    .i_lsu_we      (lsu_we),
    .i_lsu_word    (lsu_wstrb_word),
    .i_lsu_addr    (lsu_addr),
    .i_lsu_wdata   (lsu_wdata),
    .o_lsu_rdata   (lsu_rdata),
    .i_host_req    (i_host_req),
    .i_host_we     (i_host_we),
    .i_host_addr   (i_host_addr),
    .i_host_wdata  (i_host_wdata),
    .o_host_gnt    (o_host_gnt),
    .o_host_rdata  (o_host_rdata),
    .o_host_rvalid (o_host_rvalid)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
// 4 ns clock; reset high for the first 2 cycles and while i_rst_req is high
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  input  wire logic i_rst_req,
  output logic      o_clk,
  output logic      o_rst
);

  logic init_rst;

  initial begin
    o_clk    = 1'b0;
    init_rst = 1'b1;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    init_rst = 1'b0;
  end

  always #2 o_clk = ~o_clk;

  assign o_rst = init_rst || i_rst_req;

endmodule

`default_nettype wire

// ==== testbench/tb_rv_exec.sv ====
// random ops from a fixed-seed lfsr checked against a model; host port owns memory addresses 128-143
`timescale 1ns/1ps
`default_nettype none
`include "rv_exec_config.svh"

module tb_rv_exec import rv_exec_pkg::*; ();

  // ops over all tests, host fill and readback fit in the margin
  localparam int N_OPS = 250;
  localparam int CYCLE_LIMIT = 40 * N_OPS + 3000;

  logic clk;
  logic rst;
  logic rst_req;
  logic i_valid;
  logic [`RV_WORD_WD-1:0] rs1;
  logic [`RV_WORD_WD-1:0] rs2;
  logic [`RV_IMM_WD-1:0] imm;
  logic [`RV_WORD_WD-1:0] pc;
  logic [`RV_WORD_WD-1:0] csrr;
  logic src1_sel;
  src2_sel_t src2_sel;
  alu_op_t alu_op;
  logic word;
  csr_op_t csr_op;
  mem_op_t mem_op;
  logic ebreak;
  logic invalid;
  logic busy;
  logic wb_valid;
  logic [`RV_WORD_WD-1:0] wb_data;
  logic [`RV_WORD_WD-1:0] csr_result;
  logic halt;
  logic abort;
  logic h_req;
  logic h_we;
  logic [`RV_MEM_AW-1:0] h_addr;
  logic [`RV_WORD_WD-1:0] h_wdata;
  logic h_gnt;
  logic [`RV_WORD_WD-1:0] h_rdata;
  logic h_rvalid;

  logic [31:0] lfsr_q = 32'h2936_6289;
  logic [63:0] model_mem [`RV_MEM_DEPTH];
  logic [63:0] seen_wb;
  logic [63:0] seen_csr;
  // memory ops accepted one, two and three cycles ago
  logic [2:0] mem_age_q = '0;
  logic [2:0] load_age_q = '0;
  int cycles = 0;
  int checks = 0;
  int errors = 0;
  int tests = 0;
  int t_checks;
  int t_errors;

  tb_clk_gen clk_gen_i (
    .i_rst_req (rst_req),
    .o_clk     (clk),
    .o_rst     (rst)
  );

  rv_exec_top dut_i (
    .i_clk (clk), .i_rst (rst), .i_valid (i_valid),
    .i_rs1data (rs1), .i_rs2data (rs2), .i_imm (imm), .i_pc (pc), .i_csrrdata (csrr),
    .i_alu_src1_sel (src1_sel), .i_alu_src2_sel (src2_sel), .i_alu_op (alu_op),
    .i_alu_word_cut_sel (word), .i_csr_op (csr_op), .i_mem_op (mem_op),
    .i_ebreak_sel (ebreak), .i_invalid_inst_sel (invalid),
    .o_busy (busy), .o_wb_valid (wb_valid), .o_wb_data (wb_data),
    .o_csr_result (csr_result), .o_halt (halt), .o_abort (abort),
    .i_host_req (h_req), .i_host_we (h_we), .i_host_addr (h_addr),
    .i_host_wdata (h_wdata), .o_host_gnt (h_gnt), .o_host_rdata (h_rdata),
    .o_host_rvalid (h_rvalid)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // load/store request falls in the second cycle after acceptance
  always @(posedge clk) begin
    mem_age_q  <= {mem_age_q[1:0], i_valid && (mem_op != MEM_NONE)};
    load_age_q <= {load_age_q[1:0], i_valid && ((mem_op == MEM_LW) || (mem_op == MEM_LD))};
    if (!rst) begin
      // result and request cycles, plus the return cycle of a load
      check_value("o_busy", {63'b0, mem_age_q[0] || mem_age_q[1] || load_age_q[2]},
                  {63'b0, busy});
      check_value("o_host_gnt", {63'b0, h_req && !mem_age_q[1]}, {63'b0, h_gnt});
    end
  end

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = next_lfsr(lfsr_q);
      r = {r[62:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic int rand_int(input int n, input int range);
    return int'(rand_bits(n)) % range;
  endfunction

  function automatic logic [63:0] model_alu(input logic [63:0] a, input logic [63:0] b,
                                            input alu_op_t op, input logic w);
    logic [31:0] a32;
    logic [31:0] b32;
    logic [31:0] r32;
    logic [63:0] r;
    a32 = a[31:0];
    b32 = b[31:0];
    r32 = '0;
    r = '0;
    if (w) begin
      case (op)
        ALU_ADD:    r32 = a32 + b32;
        ALU_SUB:    r32 = a32 - b32;
        ALU_SLL:    r32 = a32 << b32[4:0];
        ALU_SLT:    r32 = (a32 < b32) ? 32'd1 : 32'd0;
        ALU_SLTU:   r32 = (a32 < b32) ? 32'd1 : 32'd0;
        ALU_XOR:    r32 = a32 ^ b32;
        ALU_SRL:    r32 = a32 >> b32[4:0];
        ALU_SRA:    r32 = $signed(a32) >>> b32[4:0];
        ALU_OR:     r32 = a32 | b32;
        ALU_AND:    r32 = a32 & b32;
        ALU_PASS_B: r32 = b32;
        default:    r32 = '0;
      endcase
      r = {{32{r32[31]}}, r32};
    end else begin
      case (op)
        ALU_ADD:    r = a + b;
        ALU_SUB:    r = a - b;
        ALU_SLL:    r = a << b[5:0];
        ALU_SLT:    r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        ALU_SLTU:   r = (a < b) ? 64'd1 : 64'd0;
        ALU_XOR:    r = a ^ b;
        ALU_SRL:    r = a >> b[5:0];
        ALU_SRA:    r = $signed(a) >>> b[5:0];
        ALU_OR:     r = a | b;
        ALU_AND:    r = a & b;
        ALU_PASS_B: r = b;
        default:    r = '0;
      endcase
    end
    return r;
  endfunction

  function automatic logic [63:0] model_csr(input logic [63:0] r1, input logic [63:0] c,
                                            input logic [63:0] im, input csr_op_t op,
                                            input logic use_imm);
    logic [63:0] s;
    s = use_imm ? {59'b0, im[4:0]} : r1;
    case (op)
      CSR_WRITE: return s;
      CSR_SET:   return c | s;
      CSR_CLEAR: return c & ~s;
      default:   return c;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic begin_test();
    t_checks = checks;
    t_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s done: %0d checks, %0d errors", name, checks - t_checks, errors - t_errors);
  endtask

  task automatic clear_fields();
    i_valid = 1'b0;
    src1_sel = 1'b0;
    src2_sel = SRC2_RS2;
    alu_op = ALU_ADD;
    word = 1'b0;
    csr_op = CSR_NONE;
    mem_op = MEM_NONE;
    ebreak = 1'b0;
    invalid = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      errors++;
      $display("error at %0t: o_busy stuck high for 20 cycles", $time);
    end
  endtask

  // called at a falling edge with o_busy low; returns at a falling edge
  task automatic send_op();
    i_valid = 1'b1;
    @(posedge clk);
    @(negedge clk);
    i_valid = 1'b0;
  endtask

  task automatic run_op(input int exp_lat);
    int k;
    send_op();
    if (exp_lat > 0) begin
      k = 1;
      while (!wb_valid && k < 8) begin
        @(negedge clk);
        k++;
      end
      checks++;
      if (!wb_valid) begin
        errors++;
        $display("error at %0t: no write-back within 8 cycles of the operation", $time);
      end else if (k != exp_lat) begin
        errors++;
        $display("error at %0t: write-back came after %0d cycles, not %0d", $time, k, exp_lat);
      end
      seen_wb = wb_data;
      seen_csr = csr_result;
      @(negedge clk);
    end
    wait_idle();
  endtask

  task automatic mem_access(input logic store, input logic dbl, input int idx, input logic hi,
                            input logic [63:0] data);
    logic [63:0] addr;
    logic [63:0] off;
    logic [63:0] exp;
    logic [31:0] half;
    clear_fields();
    addr = {53'b0, 8'(idx), hi, 2'b0};
    off = rand_bits(12);
    off = {{52{off[11]}}, off[11:0]};
    rs1 = addr - off;
    imm = off;
    rs2 = data;
    src2_sel = SRC2_IMM;
    if (store) begin
      mem_op = dbl ? MEM_SD : MEM_SW;
      run_op(0);
      if (dbl) begin
        model_mem[idx] = data;
      end else if (hi) begin
        model_mem[idx][63:32] = data[31:0];
      end else begin
        model_mem[idx][31:0] = data[31:0];
      end
    end else begin
      mem_op = dbl ? MEM_LD : MEM_LW;
      run_op(3);
      half = hi ? model_mem[idx][63:32] : model_mem[idx][31:0];
      exp = dbl ? model_mem[idx] : {{32{half[31]}}, half};
      check_value("o_wb_data", exp, seen_wb);
    end
    clear_fields();
  endtask

  task automatic host_access(input logic we, input logic [7:0] a, input logic [63:0] d);
    logic g;
    int n;
    h_req = 1'b1;
    h_we = we;
    h_addr = a;
    h_wdata = d;
    n = 0;
    do begin
      #1;
      g = h_gnt;
      @(negedge clk);
      n++;
    end while (!g && n < 50);
    h_req = 1'b0;
    h_we = 1'b0;
    if (!g) begin
      errors++;
      $display("error at %0t: host request never granted", $time);
    end else if (we) begin
      model_mem[a] = d;
    end else begin
      check_value("o_host_rvalid", 64'd1, {63'b0, h_rvalid});
      check_value("o_host_rdata", model_mem[a], h_rdata);
    end
  endtask

  initial begin
    logic [63:0] hdata [16];
    int kind;
    rst_req = 1'b0;
    rs1 = '0;
    rs2 = '0;
    imm = '0;
    pc = '0;
    csrr = '0;
    h_req = 1'b0;
    h_we = 1'b0;
    h_addr = '0;
    h_wdata = '0;
    clear_fields();
    @(negedge clk);
    while (rst) @(negedge clk);

    begin_test();
    for (int i = 0; i < 60; i++) begin
      rs1 = rand_bits(64);
      rs2 = rand_bits(64);
      alu_op = alu_op_t'(5'(rand_int(8, 11)));
      run_op(2);
      check_value("o_wb_data", model_alu(rs1, rs2, alu_op, 1'b0), seen_wb);
    end
    end_test("register_alu");

    begin_test();
    for (int i = 0; i < 40; i++) begin
      clear_fields();
      rs1 = rand_bits(64);
      rs2 = rand_bits(64);
      imm = rand_bits(64);
      pc = rand_bits(64);
      kind = rand_int(8, 5);
      case (kind)
        0, 1: begin
          // word forms: addw, subw, sllw, srlw, sraw and immediates
          word = 1'b1;
          src2_sel = (kind == 1) ? SRC2_IMM : SRC2_RS2;
          case (rand_int(8, 5))
            0: alu_op = ALU_ADD;
            1: alu_op = ALU_SUB;
            2: alu_op = ALU_SLL;
            3: alu_op = ALU_SRL;
            default: alu_op = ALU_SRA;
          endcase
        end
        2: begin
          src1_sel = 1'b1;
          src2_sel = SRC2_IMM;
        end
        3: begin
          src1_sel = 1'b1;
          src2_sel = SRC2_FOUR;
        end
        default: begin
          word = 1'b1;
          src2_sel = SRC2_IMM;
          alu_op = ALU_PASS_B;
        end
      endcase
      run_op(2);
      check_value("o_wb_data", model_alu(src1_sel ? pc : rs1,
                  (src2_sel == SRC2_IMM) ? imm : ((src2_sel == SRC2_FOUR) ? 64'd4 : rs2),
                  alu_op, word), seen_wb);
    end
    clear_fields();
    end_test("word_and_sources");

    begin_test();
    for (int i = 0; i < 30; i++) begin
      rs1 = rand_bits(64);
      rs2 = rand_bits(64);
      imm = rand_bits(64);
      csrr = rand_bits(64);
      csr_op = csr_op_t'(4'(1 + rand_int(8, 3)));
      src2_sel = rand_bits(1) == 64'd1 ? SRC2_IMM : SRC2_RS2;
      run_op(2);
      check_value("o_csr_result",
                  model_csr(rs1, csrr, imm, csr_op, src2_sel == SRC2_IMM), seen_csr);
    end
    clear_fields();
    end_test("csr_update");

    begin_test();
    for (int a = 0; a < `RV_MEM_DEPTH; a++) begin
      host_access(1'b1, 8'(a), {8'hA5 ^ 8'(a), 24'h13579B, 8'(a), 16'hC0DE, 8'(a) ^ 8'h3C});
    end
    for (int i = 0; i < 40; i++) begin
      mem_access(1'b1, rand_bits(1) == 64'd1, rand_int(8, 128), rand_bits(1) == 64'd1,
                 rand_bits(64));
    end
    for (int i = 0; i < 40; i++) begin
      mem_access(1'b0, rand_bits(1) == 64'd1, rand_int(8, 128), rand_bits(1) == 64'd1, '0);
    end
    for (int a = 0; a < 128; a++) begin
      host_access(1'b0, 8'(a), '0);
    end
    end_test("store_load");

    begin_test();
    for (int i = 0; i < 16; i++) begin
      hdata[i] = rand_bits(64);
    end
    fork
      begin
        for (int i = 0; i < 20; i++) begin
          mem_access(i % 2 == 0, rand_bits(1) == 64'd1, rand_int(8, 64),
                     rand_bits(1) == 64'd1, rand_bits(64));
        end
      end
      begin
        for (int i = 0; i < 16; i++) begin
          host_access(1'b1, 8'(128 + i), hdata[i]);
        end
      end
    join
    for (int i = 0; i < 16; i++) begin
      mem_access(1'b0, 1'b1, 128 + i, 1'b0, '0);
    end
    end_test("host_traffic");

    begin_test();
    clear_fields();
    ebreak = 1'b1;
    send_op();
    ebreak = 1'b0;
    check_value("o_halt", 64'd1, {63'b0, halt});
    rs1 = rand_bits(64);
    send_op();
    repeat (5) begin
      checks++;
      if (wb_valid) begin
        errors++;
        $display("error at %0t: write-back seen while halted", $time);
      end
      @(negedge clk);
    end
    check_value("o_halt", 64'd1, {63'b0, halt});
    rst_req = 1'b1;
    repeat (2) @(negedge clk);
    rst_req = 1'b0;
    check_value("o_halt", 64'd0, {63'b0, halt});
    check_value("o_abort", 64'd0, {63'b0, abort});
    invalid = 1'b1;
    send_op();
    invalid = 1'b0;
    check_value("o_abort", 64'd1, {63'b0, abort});
    send_op();
    repeat (5) begin
      checks++;
      if (wb_valid) begin
        errors++;
        $display("error at %0t: write-back seen after abort", $time);
      end
      @(negedge clk);
    end
    check_value("o_abort", 64'd1, {63'b0, abort});
    end_test("halt_abort");

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/rv_exec_pkg.sv
source/rv_alu.sv
source/rv_csu.sv
source/rv_exu.sv
source/rv_lsu.sv
source/rv_shared_dmem.sv
source/rv_exec_top.sv
testbench/tb_clk_gen.sv
testbench/tb_rv_exec.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module tb_rv_exec -Mdir obj_dir -o tb_rv_exec_sim \
  && ./obj_dir/tb_rv_exec_sim | tee /dev/stderr | grep -qF "STATUS: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
